// File: design/cpuPkg.sv
// Shared widths, opcodes, ALU function codes and the host address map, imported by every core module
`default_nettype none
package cpuPkg;

   localparam int DataWidth    = 16;  // Data path and register width
   localparam int RegAddrWidth = 3;   // Eight architectural registers
   localparam int ImemDepth    = 256; // Instruction memory size in 16-bit words

   // Major opcodes in instr[15:11]
   localparam logic [4:0] OpHalt  = 5'b00000;
   localparam logic [4:0] OpNop   = 5'b00001;
   localparam logic [4:0] OpJ     = 5'b00100;
   localparam logic [4:0] OpJr    = 5'b00101;
   localparam logic [4:0] OpJal   = 5'b00110;
   localparam logic [4:0] OpJalr  = 5'b00111;
   localparam logic [4:0] OpAddi  = 5'b01000;
   localparam logic [4:0] OpSubi  = 5'b01001;
   localparam logic [4:0] OpXori  = 5'b01010;
   localparam logic [4:0] OpAndni = 5'b01011;
   localparam logic [4:0] OpBeqz  = 5'b01100;
   localparam logic [4:0] OpBnez  = 5'b01101;
   localparam logic [4:0] OpBltz  = 5'b01110;
   localparam logic [4:0] OpBgez  = 5'b01111;
   localparam logic [4:0] OpLbi   = 5'b11000;
   localparam logic [4:0] OpAlu   = 5'b11011; // Register form, function in instr[1:0]

   // Function field of OpAlu, also used as the ALU operation select
   localparam logic [1:0] FnAdd  = 2'b00;
   localparam logic [1:0] FnSub  = 2'b01;
   localparam logic [1:0] FnXor  = 2'b10;
   localparam logic [1:0] FnAndn = 2'b11;

   localparam logic [RegAddrWidth-1:0] LinkReg = 3'd7; // Written by JAL and JALR

   // Host address map in byte addresses on the 12-bit APB address
   localparam logic [11:0] ImemBase   = 12'h000; // Write only, 2 bytes per word
   localparam logic [11:0] RegBase    = 12'h400; // Read only, 2 bytes per register
   localparam logic [11:0] CtrlAddr   = 12'h800; // Bit 0 written high starts a run
   localparam logic [11:0] StatusAddr = 12'h804; // Bit 0 running, bit 1 halted

endpackage
`default_nettype wire

// File: design/executeUnit.sv
// Combinational ALU shared by the immediate and register arithmetic forms
`default_nettype none
module executeUnit import cpuPkg::*; (
   input  logic [DataWidth-1:0] aluA,
   input  logic [DataWidth-1:0] aluB,
   input  logic [1:0]           aluOp,
   output logic [DataWidth-1:0] aluResult
);

   logic [DataWidth-1:0] sum;
   logic [DataWidth-1:0] diff;
   logic [DataWidth-1:0] parity;
   logic [DataWidth-1:0] masked;

   // A is always Rs, B is the immediate or Rt

   assign sum    = aluA + aluB;
   assign diff   = aluB - aluA; // WISC subtracts Rs from the other operand
   assign parity = aluA ^ aluB;
   assign masked = aluA & ~aluB; // Clears in Rs the bits set in B

   always_comb begin
      case (aluOp)
         FnAdd:   aluResult = sum;
         FnSub:   aluResult = diff;
         FnXor:   aluResult = parity;
         FnAndn:  aluResult = masked;
         default: aluResult = sum; // Only reachable with X on the select
      endcase
   end

endmodule
`default_nettype wire

// File: design/regFile.sv
// Eight-entry register file with two core read ports, a host debug read port and one write port
`default_nettype none
module regFile import cpuPkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [RegAddrWidth-1:0] rsAddr,
   input  logic [RegAddrWidth-1:0] rtAddr,
   input  logic [RegAddrWidth-1:0] wrAddr,
   input  logic [RegAddrWidth-1:0] dbgAddr,
   input  logic                    wrEn,
   input  logic [DataWidth-1:0]    wrData,
   output logic [DataWidth-1:0]    rsData,
   output logic [DataWidth-1:0]    rtData,
   output logic [DataWidth-1:0]    dbgData
);

   logic [DataWidth-1:0] regs [2**RegAddrWidth];

   // Writeback lands at the edge that closes the instruction's cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**RegAddrWidth; i++) begin
            regs[i] <= '0; // Programs may rely on a clean register file
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Reads see the old value during the writing cycle, which is what a
   // single-stage execute expects since the write lands after the read
   assign rsData  = regs[rsAddr];
   assign rtData  = regs[rtAddr];
   assign dbgData = regs[dbgAddr]; // Host view, only meaningful once halted

   // Once reset has been held for a cycle the fetch register is empty, so
   // decode must not be requesting writes
   assert property (@(posedge clk) (rst && $past(rst)) |-> !wrEn)
      else $error("Register write requested during reset");

endmodule
`default_nettype wire

// File: design/fetchStage.sv
// Fetch stage holding the PC, the host-loaded instruction memory and the fetch pipeline register
`default_nettype none
module fetchStage import cpuPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   input  logic                 imemWrEn,
   input  logic [7:0]           imemAddr,
   input  logic [DataWidth-1:0] imemData,
   input  logic [DataWidth-1:0] target,
   input  logic                 pcSel,
   input  logic                 start,
   output logic [DataWidth-1:0] instr,
   output logic [DataWidth-1:0] instrPc,
   output logic                 instrValid
);

   logic [DataWidth-1:0] mem [ImemDepth];
   logic [DataWidth-1:0] pc;
   logic [DataWidth-1:0] memWord;
   logic                 bubble;

   // Host loads the program one word at a time while the core is idle
   always_ff @(posedge clk) begin
      if (imemWrEn) begin
         mem[imemAddr] <= imemData;
      end
   end

   assign memWord = mem[pc[8:1]]; // Byte PC, word-indexed memory
   assign bubble  = pcSel || !run; // Redirect or stopped core both squash the fetch

   // PC and valid flag are control state
   always_ff @(posedge clk) begin
      if (rst || start) begin
         pc         <= '0; // A run always begins at address 0
         instrValid <= 1'b0;
      end else if (run) begin
         pc         <= pcSel ? target : pc + DataWidth'(2);
         instrValid <= !pcSel; // Taken branch costs one bubble cycle
      end else begin
         instrValid <= 1'b0;
      end
   end

   // Instruction word and its address travel together into decode
   always_ff @(posedge clk) begin
      instr   <= bubble ? {OpNop, 11'b0} : memWord;
      instrPc <= pc;
   end

endmodule
`default_nettype wire

// File: design/decodeStage.sv
// Second-stage decode that picks operands, forms writeback and resolves branches and jumps
`default_nettype none
module decodeStage import cpuPkg::*; (
   input  logic [DataWidth-1:0]    instr,
   input  logic [DataWidth-1:0]    instrPc,
   input  logic                    instrValid,
   input  logic [DataWidth-1:0]    rsData,
   input  logic [DataWidth-1:0]    rtData,
   input  logic [DataWidth-1:0]    aluResult,
   output logic [RegAddrWidth-1:0] rsAddr,
   output logic [RegAddrWidth-1:0] rtAddr,
   output logic [RegAddrWidth-1:0] wrAddr,
   output logic                    wrEn,
   output logic [DataWidth-1:0]    wrData,
   output logic [DataWidth-1:0]    aluA,
   output logic [DataWidth-1:0]    aluB,
   output logic [1:0]              aluOp,
   output logic                    pcSel,
   output logic [DataWidth-1:0]    target,
   output logic                    halt
);

   logic [4:0]           op;
   logic [DataWidth-1:0] imm5, imm8, imm11;
   logic [DataWidth-1:0] pcPlus2;
   logic                 isImmAlu, isRegAlu, isLbi, isBranch, isJump, isRegJump, isLink;
   logic                 zeroFlag, signFlag, taken;

   assign op     = instr[15:11];
   assign rsAddr = instr[10:8];
   assign rtAddr = instr[7:5];

   // Sign extension for the three immediate widths
   assign imm5  = {{(DataWidth-5){instr[4]}}, instr[4:0]};
   assign imm8  = {{(DataWidth-8){instr[7]}}, instr[7:0]};
   assign imm11 = {{(DataWidth-11){instr[10]}}, instr[10:0]};

   assign pcPlus2 = instrPc + DataWidth'(2); // Link value and base of relative targets

   always_comb begin
      isImmAlu  = (op == OpAddi) || (op == OpSubi) || (op == OpXori) || (op == OpAndni);
      isRegAlu  = (op == OpAlu);
      isLbi     = (op == OpLbi);
      isBranch  = (op == OpBeqz) || (op == OpBnez) || (op == OpBltz) || (op == OpBgez);
      isJump    = (op == OpJ) || (op == OpJal);    // PC-relative, 11-bit displacement
      isRegJump = (op == OpJr) || (op == OpJalr);  // Rs plus 8-bit immediate
      isLink    = (op == OpJal) || (op == OpJalr);
   end

   // Immediate forms take Rs and the immediate, register forms Rs and Rt
   always_comb begin
      aluA = rsData;
      aluB = isRegAlu ? rtData : imm5;
      case (op)
         OpSubi:  aluOp = FnSub;
         OpXori:  aluOp = FnXor;
         OpAndni: aluOp = FnAndn;
         OpAlu:   aluOp = instr[1:0]; // Function field matches the ALU select
         default: aluOp = FnAdd;
      endcase
   end

   // Destination differs by format and links always go to the link register
   always_comb begin
      if (isLink)        wrAddr = LinkReg;
      else if (isLbi)    wrAddr = instr[10:8]; // LBI loads Rs itself
      else if (isRegAlu) wrAddr = instr[4:2];
      else               wrAddr = instr[7:5];
   end

   // Link write is forced on for JALR just as for JAL
   assign wrEn   = instrValid && (isImmAlu || isRegAlu || isLbi || isLink);
   assign wrData = isLink ? pcPlus2 : (isLbi ? imm8 : aluResult);

   // Branch conditions look only at Rs
   assign zeroFlag = (rsData == '0);
   assign signFlag = rsData[DataWidth-1];

   always_comb begin
      case (op[1:0])
         2'b00:   taken = zeroFlag;   // BEQZ
         2'b01:   taken = !zeroFlag;  // BNEZ
         2'b10:   taken = signFlag;   // BLTZ
         default: taken = !signFlag;  // BGEZ
      endcase
   end

   assign target = isRegJump ? rsData + imm8 : pcPlus2 + (isJump ? imm11 : imm8);
   assign pcSel  = instrValid && ((isBranch && taken) || isJump || isRegJump);
   assign halt   = instrValid && (op == OpHalt); // Bubbles carry NOP so never halt

   always_comb begin
      assert final (!(pcSel && halt)) else $error("Redirect and halt raised together");
   end

endmodule
`default_nettype wire

// File: design/hostPort.sv
// APB slave that loads the program, starts runs, reports status and exposes registers after halt
`default_nettype none
module hostPort import cpuPkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [11:0]             paddr,
   input  logic [DataWidth-1:0]    pwdata,
   input  logic                    halt,
   input  logic [DataWidth-1:0]    dbgData,
   output logic [DataWidth-1:0]    prdata,
   output logic                    pready,
   output logic                    pslverr,
   output logic                    imemWrEn,
   output logic [7:0]              imemAddr,
   output logic [DataWidth-1:0]    imemData,
   output logic                    run,
   output logic                    start,
   output logic [RegAddrWidth-1:0] dbgAddr
);

   logic                 running, halted;
   logic                 imemHit, regHit, ctrlHit, statusHit, unmapped;
   logic                 setupPhase, accessDone, accessErr;
   logic [DataWidth-1:0] readValue;

   // Odd byte addresses match nothing
   assign imemHit   = (paddr[11:9] == ImemBase[11:9]) && !paddr[0];
   assign regHit    = (paddr[11:4] == RegBase[11:4]) && !paddr[0];
   assign ctrlHit   = (paddr == CtrlAddr);
   assign statusHit = (paddr == StatusAddr);
   assign unmapped  = !(imemHit || regHit || ctrlHit || statusHit);

   assign setupPhase = psel && !penable;
   assign accessDone = psel && penable && pready && !pslverr; // Faulted transfers do nothing

   always_comb begin
      accessErr = unmapped;
      if (pwrite) begin
         if (regHit || statusHit)             accessErr = 1'b1; // Read-only spaces
         if ((imemHit || ctrlHit) && running) accessErr = 1'b1; // No reload or restart mid-run
      end else if (regHit && running) begin
         accessErr = 1'b1; // Registers are only stable after halt
      end
   end

   always_comb begin
      if (statusHit)   readValue = {{(DataWidth-2){1'b0}}, halted, running};
      else if (regHit) readValue = dbgData;
      else             readValue = '0; // Memory and control read back as zero
   end

   // Response is prepared in the setup cycle so the first access cycle completes
   always_ff @(posedge clk) begin
      if (rst) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
         prdata  <= '0;
      end else begin
         pready  <= setupPhase;
         pslverr <= setupPhase && accessErr;
         if (setupPhase) prdata <= (pwrite || accessErr) ? '0 : readValue;
      end
   end

   assign imemWrEn = accessDone && pwrite && imemHit;
   assign imemAddr = paddr[8:1];
   assign imemData = pwdata;
   assign start    = accessDone && pwrite && ctrlHit && pwdata[0];
   assign dbgAddr  = paddr[RegAddrWidth:1];
   assign run      = running && !halt; // Fetch stops at the same edge that retires HALT

   // Start and halt cannot coincide since start is refused while running
   always_ff @(posedge clk) begin
      if (rst) begin
         running <= 1'b0;
         halted  <= 1'b0;
      end else if (start) begin
         running <= 1'b1;
         halted  <= 1'b0;
      end else if (halt) begin
         running <= 1'b0;
         halted  <= 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (rst) pready |-> (psel && penable))
      else $error("pready high outside an APB access phase");

endmodule
`default_nettype wire

// File: design/cpuCore.sv
// Top level of the two-stage core, wiring the APB host port to fetch, decode, ALU and registers
`default_nettype none
module cpuCore import cpuPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [11:0]          paddr,
   input  logic [DataWidth-1:0] pwdata,
   output logic [DataWidth-1:0] prdata,
   output logic                 pready,
   output logic                 pslverr
);

   logic                    imemWrEn, run, start, halt, instrValid, wrEn, pcSel;
   logic [7:0]              imemAddr;
   logic [DataWidth-1:0]    imemData, instr, instrPc, target, wrData;
   logic [DataWidth-1:0]    rsData, rtData, dbgData, aluA, aluB, aluResult;
   logic [RegAddrWidth-1:0] rsAddr, rtAddr, wrAddr, dbgAddr;
   logic [1:0]              aluOp;

   hostPort hostPort_inst (
      .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .halt(halt), .dbgData(dbgData), .prdata(prdata),
      .pready(pready), .pslverr(pslverr), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
      .imemData(imemData), .run(run), .start(start), .dbgAddr(dbgAddr)
   );

   fetchStage fetchStage_inst (
      .clk(clk), .rst(rst), .run(run), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
      .imemData(imemData), .target(target), .pcSel(pcSel), .start(start),
      .instr(instr), .instrPc(instrPc), .instrValid(instrValid)
   );

   // Decode, ALU and register file together form the single execute stage
   decodeStage decodeStage_inst (
      .instr(instr), .instrPc(instrPc), .instrValid(instrValid), .rsData(rsData),
      .rtData(rtData), .aluResult(aluResult), .rsAddr(rsAddr), .rtAddr(rtAddr),
      .wrAddr(wrAddr), .wrEn(wrEn), .wrData(wrData), .aluA(aluA), .aluB(aluB),
      .aluOp(aluOp), .pcSel(pcSel), .target(target), .halt(halt)
   );

   executeUnit executeUnit_inst (.aluA(aluA), .aluB(aluB), .aluOp(aluOp), .aluResult(aluResult));

   regFile regFile_inst (
      .clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr),
      .dbgAddr(dbgAddr), .wrEn(wrEn), .wrData(wrData), .rsData(rsData),
      .rtData(rtData), .dbgData(dbgData)
   );

endmodule
`default_nettype wire

// File: tests/cpuCoreTb.sv
// Testbench for cpuCore that runs programs loaded over APB and checks registers against an ISA model
`default_nettype none
module cpuCoreTb import cpuPkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NumRegs     = 2**RegAddrWidth;
   localparam int NumPrograms = 5;
   localparam int CycleLimit  = 200 * NumPrograms + 2000;

   logic clk, rst, psel, penable, pwrite, pready, pslverr;
   logic [11:0]            paddr;
   logic [DataWidth-1:0]   pwdata, prdata;
   logic [DataWidth-1:0]   prog [ImemDepth]; // Program image shared by loader and model
   int                     progLen;
   logic [NumRegs*DataWidth-1:0] modelRegs;  // Register state carried from run to run
   int                     cycles, dataErrs, respErrs;
   string                  dataName [$], respName [$];
   logic [DataWidth-1:0]   dataGot [$], dataExp [$];
   logic                   respGot [$], respExp [$];

   cpuCore cpuCore_inst (
      .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   always #10 clk = ~clk;

   // Hard stop in case the core never halts or the bus never answers
   always @(posedge clk) begin
      cycles++;
      if (cycles >= CycleLimit) begin
         $display("Run did not finish within %0d cycles", CycleLimit);
         $display("Test failed");
         $finish;
      end
   end

   task automatic checkData(input string name, input logic [DataWidth-1:0] got, exp);
      if (got !== exp) begin
         dataErrs++;
         $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic checkErr(input string name, input logic got, exp);
      if (got !== exp) begin
         respErrs++;
         $display("Error pslverr on %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // Results are compared away from the driving edge, in the order they were taken
   always @(negedge clk) begin
      while (dataGot.size() > 0)
         checkData(dataName.pop_front(), dataGot.pop_front(), dataExp.pop_front());
      while (respGot.size() > 0)
         checkErr(respName.pop_front(), respGot.pop_front(), respExp.pop_front());
   end

   task automatic queueData(input string name, input logic [DataWidth-1:0] got, exp);
      dataName.push_back(name);
      dataGot.push_back(got);
      dataExp.push_back(exp);
   endtask

   task automatic queueErr(input string name, input logic got, exp);
      respName.push_back(name);
      respGot.push_back(got);
      respExp.push_back(exp);
   endtask

   // Setup cycle, then access cycles until pready, sampled 2 ns into the cycle
   task automatic apbTransfer(input logic wr, input logic [11:0] addr,
                              input logic [DataWidth-1:0] wdata,
                              output logic [DataWidth-1:0] rdata, output logic err);
      int waits;
      @(posedge clk);
      #2 psel = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #2 penable = 1'b1;
      waits = 0;
      while (pready !== 1'b1) begin
         @(posedge clk);
         #2;
         waits++;
      end
      // The slave answers every access in its first access cycle
      if (waits != 0) begin
         respErrs++;
         $display("pready came %0d cycles late on the transfer at address 0x%h", waits, addr);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk); // Transfer completes at this edge
      #2 psel = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apbWrite(input logic [11:0] addr, input logic [DataWidth-1:0] data,
                           output logic err);
      logic [DataWidth-1:0] unused;
      apbTransfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apbRead(input logic [11:0] addr, output logic [DataWidth-1:0] data,
                          output logic err);
      apbTransfer(1'b0, addr, '0, data, err);
   endtask

   // Instruction word builders, one per format
   function automatic logic [15:0] immWord(input logic [4:0] op, input logic [2:0] rs, rd,
                                           input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] regWord(input logic [2:0] rs, rt, rd, input logic [1:0] fn);
      return {OpAlu, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] lbiWord(input logic [2:0] rs, input logic [7:0] imm);
      return {OpLbi, rs, imm};
   endfunction

   function automatic logic [15:0] branchWord(input logic [4:0] op, input logic [2:0] rs,
                                              input logic [7:0] imm);
      return {op, rs, imm}; // Also the JR and JALR format
   endfunction

   function automatic logic [15:0] jumpWord(input logic [4:0] op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   task automatic emit(input logic [15:0] word);
      prog[progLen] = word;
      progLen++;
   endtask

   // ISA model that runs the program image from PC 0 until HALT
   function automatic logic [NumRegs*DataWidth-1:0] interpretProgram(
         input logic [NumRegs*DataWidth-1:0] startRegs);
      logic [DataWidth-1:0] r [NumRegs];
      logic [DataWidth-1:0] pc, w, nextPc, linkPc, imm5, imm8, imm11;
      logic [2:0]           rs, rt;
      logic [NumRegs*DataWidth-1:0] result;
      bit                   done;
      int                   steps;
      for (int i = 0; i < NumRegs; i++) r[i] = startRegs[i*DataWidth +: DataWidth];
      pc    = '0;
      done  = 0;
      steps = 0;
      while (!done && steps < 4096) begin
         w      = prog[pc[8:1]];
         rs     = w[10:8];
         rt     = w[7:5];
         imm5   = {{(DataWidth-5){w[4]}}, w[4:0]};
         imm8   = {{(DataWidth-8){w[7]}}, w[7:0]};
         imm11  = {{(DataWidth-11){w[10]}}, w[10:0]};
         linkPc = pc + 16'd2;
         nextPc = linkPc; // Fall through unless redirected
         case (w[15:11])
            OpHalt:  done = 1;
            OpAddi:  r[rt] = r[rs] + imm5;
            OpSubi:  r[rt] = imm5 - r[rs]; // Immediate minus Rs
            OpXori:  r[rt] = r[rs] ^ imm5;
            OpAndni: r[rt] = r[rs] & ~imm5;
            OpAlu: begin
               case (w[1:0])
                  FnAdd:   r[w[4:2]] = r[rs] + r[rt];
                  FnSub:   r[w[4:2]] = r[rt] - r[rs];
                  FnXor:   r[w[4:2]] = r[rs] ^ r[rt];
                  default: r[w[4:2]] = r[rs] & ~r[rt];
               endcase
            end
            OpLbi:   r[rs] = imm8;
            OpBeqz:  if (r[rs] == '0) nextPc = linkPc + imm8;
            OpBnez:  if (r[rs] != '0) nextPc = linkPc + imm8;
            OpBltz:  if (r[rs][DataWidth-1]) nextPc = linkPc + imm8;
            OpBgez:  if (!r[rs][DataWidth-1]) nextPc = linkPc + imm8;
            OpJ:     nextPc = linkPc + imm11;
            OpJr:    nextPc = r[rs] + imm8;
            OpJal: begin
               nextPc     = linkPc + imm11;
               r[LinkReg] = linkPc;
            end
            OpJalr: begin
               nextPc     = r[rs] + imm8; // Rs is read before the link lands
               r[LinkReg] = linkPc;
            end
            default: ; // NOP
         endcase
         pc = nextPc;
         steps++;
      end
      for (int i = 0; i < NumRegs; i++) result[i*DataWidth +: DataWidth] = r[i];
      return result;
   endfunction

   task automatic loadProgram();
      logic err;
      for (int i = 0; i < progLen; i++) begin
         apbWrite(ImemBase + 12'(2*i), prog[i], err);
         queueErr("instruction load", err, 1'b0);
      end
   endtask

   task automatic startRun();
      logic err;
      apbWrite(CtrlAddr, 16'h0001, err);
      queueErr("start write", err, 1'b0);
   endtask

   // Polls for halt, then reads every register back against the model
   task automatic finishRun();
      logic [DataWidth-1:0] status, got;
      logic [NumRegs*DataWidth-1:0] expRegs;
      logic err;
      status = '0;
      while (!status[1]) apbRead(StatusAddr, status, err);
      queueData("prdata status after halt", status, 16'h0002);
      expRegs = interpretProgram(modelRegs);
      for (int i = 0; i < NumRegs; i++) begin
         apbRead(RegBase + 12'(2*i), got, err);
         queueData($sformatf("prdata r%0d", i), got, expRegs[i*DataWidth +: DataWidth]);
         queueErr("register read", err, 1'b0);
      end
      modelRegs = expRegs;
   endtask

   initial begin
      logic [4:0]           immOps [4];
      logic [4:0]           brOps [4];
      logic [7:0]           val;
      logic [DataWidth-1:0] rd;
      logic                 err;
      int                   pick;
      void'($urandom(32'hf3c23532));
      immOps  = '{OpAddi, OpSubi, OpXori, OpAndni};
      brOps   = '{OpBeqz, OpBnez, OpBltz, OpBgez};
      clk     = 1'b0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      cycles  = 0;
      dataErrs  = 0;
      respErrs  = 0;
      modelRegs = '0; // Registers come out of reset cleared
      repeat (3) @(posedge clk);
      #2 rst = 1'b0;

      // Straight-line arithmetic on random operands
      progLen = 0;
      for (int i = 0; i < NumRegs; i++) emit(lbiWord(3'(i), 8'($urandom)));
      for (int k = 0; k < 12; k++) begin
         pick = $urandom_range(7, 0);
         if (pick < 4)
            emit(immWord(immOps[pick], 3'($urandom), 3'($urandom), 5'($urandom)));
         else
            emit(regWord(3'($urandom), 3'($urandom), 3'($urandom), 2'(pick)));
      end
      emit({OpHalt, 11'b0});
      loadProgram();
      startRun();
      finishRun();

      // Every branch kind on zero, positive and negative Rs
      progLen = 0;
      for (int c = 0; c < 4; c++) begin
         for (int v = 0; v < 3; v++) begin
            case (v)
               0:       val = 8'h00;
               1:       val = 8'($urandom_range(127, 1));
               default: val = 8'($urandom_range(255, 128));
            endcase
            emit(lbiWord(3'd1, val));
            emit(branchWord(brOps[c], 3'd1, 8'd2));  // Taken skips the next word
            emit(immWord(OpAddi, 3'd6, 3'd6, 5'd1)); // Bumps r6 only on fall-through
         end
      end
      emit({OpHalt, 11'b0});
      loadProgram();
      startRun();
      finishRun();

      // Jumps with and without link, byte addresses in the comments
      progLen = 0;
      emit(jumpWord(OpJ, 11'd2));               // 0 goes to 4
      emit(lbiWord(3'd1, 8'h11));               // 2 jumped over
      emit(jumpWord(OpJal, 11'd2));             // 4 links 6 and goes to 8
      emit(lbiWord(3'd2, 8'h22));               // 6 jumped over
      emit(immWord(OpAddi, 3'd7, 3'd3, 5'd0));  // 8 copies the link into r3
      emit(lbiWord(3'd4, 8'd20));
      emit(branchWord(OpJr, 3'd4, 8'd2));       // 12 goes to 22
      for (int i = 0; i < 4; i++) emit(lbiWord(3'd5, 8'h55));
      emit(lbiWord(3'd4, 8'd24));               // 22
      emit(branchWord(OpJalr, 3'd4, 8'd6));     // 24 links 26 and goes to 30
      emit(lbiWord(3'd6, 8'h66));
      emit(lbiWord(3'd6, 8'h77));
      emit({OpHalt, 11'b0});                    // 30
      loadProgram();
      startRun();
      finishRun();

      // Negative immediates and a backward branch
      progLen = 0;
      emit(lbiWord(3'd1, 8'hfd));
      emit(immWord(OpAddi, 3'd1, 3'd2, 5'h10));
      emit(immWord(OpSubi, 3'd1, 3'd3, 5'h19));
      emit(lbiWord(3'd4, 8'd4));
      emit(immWord(OpAddi, 3'd4, 3'd4, 5'h1f)); // 8 loop head
      emit(immWord(OpAddi, 3'd5, 3'd5, 5'h1e));
      emit(branchWord(OpBnez, 3'd4, 8'hfa));    // 12 back to 8
      emit(lbiWord(3'd6, 8'h80));
      emit({OpHalt, 11'b0});
      loadProgram();
      startRun();
      finishRun();

      // Long countdown so host accesses land mid-run
      progLen = 0;
      emit(lbiWord(3'd1, 8'd60));
      emit(immWord(OpAddi, 3'd1, 3'd1, 5'h1f));
      emit(branchWord(OpBnez, 3'd1, 8'hfc));
      emit(lbiWord(3'd2, 8'h33)); // 6 the refused write aims here
      emit({OpHalt, 11'b0});
      loadProgram();
      startRun();
      apbRead(StatusAddr, rd, err);
      queueData("prdata status while running", rd, 16'h0001);
      queueErr("status read", err, 1'b0);
      apbWrite(ImemBase + 12'd6, lbiWord(3'd2, 8'h44), err);
      queueErr("instruction write while running", err, 1'b1);
      apbRead(RegBase + 12'd2, rd, err);
      queueErr("register read while running", err, 1'b1);
      apbWrite(StatusAddr, 16'h0003, err);
      queueErr("status write", err, 1'b1);
      apbWrite(12'h900, 16'hffff, err);
      queueErr("unmapped write", err, 1'b1);
      apbRead(12'hc00, rd, err);
      queueErr("unmapped read", err, 1'b1);
      finishRun();

      while (dataGot.size() != 0 || respGot.size() != 0) @(negedge clk);
      @(posedge clk);
      $display("Data mismatches: %0d, response errors: %0d", dataErrs, respErrs);
      if (dataErrs + respErrs == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule
`default_nettype wire

// File: vlog.f
design/cpuPkg.sv
design/executeUnit.sv
design/regFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/hostPort.sv
design/cpuCore.sv
tests/cpuCoreTb.sv
